/* source/alu_isa_pkg.sv */
package alu_isa_pkg;

    // word layout seen at the ports
    localparam int DATA_W = 16;  // fixed, the LFSR taps assume 16 bits
    localparam int INST_W = 4;

    // signed fixed-point word, binary point set by FRAC_W in the RTL
    typedef logic signed [DATA_W-1:0] data_t;

    // instruction codes
    // 4 and 8..15 are not supported and return 0
    typedef enum logic [INST_W-1:0] {
        INST_ADD  = 4'd0,  // saturating add
        INST_SUB  = 4'd1,  // saturating subtract
        INST_MUL  = 4'd2,  // saturating, rounded multiply
        INST_MAC  = 4'd3,  // a*b + previous result
        INST_CLZ  = 4'd5,  // leading zeros of a
        INST_LRCW = 4'd6,  // b complement-rotated popcount(a) times
        INST_LFSR = 4'd7   // a stepped b times
    } inst_e;

    // feedback taps 15, 13, 12, 10
    localparam logic [DATA_W-1:0] LFSR_TAPS = 16'hB400;

endpackage

/* source/alu_ctrl_pkg.sv */
package alu_ctrl_pkg;

    // operand source for either input of the arithmetic unit
    typedef enum logic [2:0] {
        SRC_DATA_A,    // i_data_a
        SRC_DATA_B,    // i_data_b
        SRC_SAVED,     // saved-operand register
        SRC_RESULT,    // result register, o_data
        SRC_GPR_ROT,   // complement-rotate register
        SRC_GPR_LFSR,  // LFSR register
        SRC_COUNT      // step counter 0
    } src_e;

    // operation of the arithmetic unit
    typedef enum logic [1:0] {
        OP_ADD,     // saturating add
        OP_SUB,     // saturating subtract
        OP_MUL,     // saturating rounded multiply
        OP_PASS_A   // a straight through
    } op_e;

endpackage

/* source/fx_arith.sv */
`timescale 1ns/1ps

module fx_arith import alu_isa_pkg::*, alu_ctrl_pkg::*; #(
    parameter int FRAC_W = 10
) (
    input  op_e   i_op,
    input  data_t i_a,
    input  data_t i_b,
    output data_t o_y
);

    localparam int INT_W   = DATA_W - FRAC_W;
    localparam int MAX_INT = 2 ** (INT_W - 1) - 1;  // largest integer part
    localparam int MIN_INT = -(2 ** (INT_W - 1));

    localparam data_t POS_SAT = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t NEG_SAT = {1'b1, {(DATA_W-1){1'b0}}};

    data_t sum, diff;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [2*INT_W-1:0]  prod_int;  // integer part of the full product

    assign sum      = i_a + i_b;
    assign diff     = i_a - i_b;
    assign prod     = i_a * i_b;
    assign prod_int = $signed(prod[2*DATA_W-1:2*FRAC_W]);

    always_comb begin
        case (i_op)
            OP_ADD: begin
                if (!i_a[DATA_W-1] && !i_b[DATA_W-1] && sum[DATA_W-1])
                    o_y = POS_SAT;
                else if (i_a[DATA_W-1] && i_b[DATA_W-1] && !sum[DATA_W-1])
                    o_y = NEG_SAT;
                else
                    o_y = sum;
            end
            OP_SUB: begin
                // overflow only when the signs differ
                if (!i_a[DATA_W-1] && i_b[DATA_W-1] && diff[DATA_W-1])
                    o_y = POS_SAT;
                else if (i_a[DATA_W-1] && !i_b[DATA_W-1] && !diff[DATA_W-1])
                    o_y = NEG_SAT;
                else
                    o_y = diff;
            end
            OP_MUL: begin
                if (prod_int > MAX_INT)
                    o_y = POS_SAT;
                else if (prod_int <= MIN_INT)
                    o_y = NEG_SAT;
                else  // round half up on the dropped fraction bits
                    o_y = prod[DATA_W-1+FRAC_W:FRAC_W]
                          + {{(DATA_W-1){1'b0}}, prod[FRAC_W-1]};
            end
            default: o_y = i_a;  // pass a
        endcase
    end

endmodule

/* source/scramble_regs.sv */
`timescale 1ns/1ps

module scramble_regs import alu_isa_pkg::*; (
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  logic  i_load_rot,
    input  logic  i_step_rot,
    input  logic  i_load_lfsr,
    input  logic  i_step_lfsr,
    input  data_t i_value,
    output data_t o_rot,
    output data_t o_lfsr
);

    logic fb;  // lfsr feedback bit

    assign fb = ^(o_lfsr & LFSR_TAPS);

    // complement-rotate register, load wins over step
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_rot <= '0;
        end else if (i_load_rot) begin
            o_rot <= i_value;
        end else if (i_step_rot) begin
            o_rot <= {o_rot[DATA_W-2:0], ~o_rot[DATA_W-1]};
        end
    end

    // fibonacci lfsr, shifts left
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_lfsr <= '0;
        end else if (i_load_lfsr) begin
            o_lfsr <= i_value;
        end else if (i_step_lfsr) begin
            o_lfsr <= {o_lfsr[DATA_W-2:0], fb};
        end
    end

endmodule

/* source/alu_datapath.sv */
`timescale 1ns/1ps

module alu_datapath import alu_isa_pkg::*, alu_ctrl_pkg::*; #(
    parameter int FRAC_W = 10
) (
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  data_t i_data_a,
    input  data_t i_data_b,
    input  src_e  i_src_a,
    input  src_e  i_src_b,
    input  op_e   i_op,
    input  logic  i_save_result,
    input  logic  i_save_operand,
    input  logic  i_load_rot,
    input  logic  i_step_rot,
    input  logic  i_load_lfsr,
    input  logic  i_step_lfsr,
    input  data_t i_count,
    output data_t o_saved,
    output data_t o_data
);

    data_t opnd_a, opnd_b;
    data_t arith_y;
    data_t rot, lfsr;

    // same selection for both operand inputs
    function automatic data_t pick(input src_e sel);
        case (sel)
            SRC_DATA_A:   return i_data_a;
            SRC_DATA_B:   return i_data_b;
            SRC_SAVED:    return o_saved;
            SRC_RESULT:   return o_data;
            SRC_GPR_ROT:  return rot;
            SRC_GPR_LFSR: return lfsr;
            SRC_COUNT:    return i_count;
            default:      return '0;
        endcase
    endfunction

    assign opnd_a = pick(i_src_a);
    assign opnd_b = pick(i_src_b);

    fx_arith #(
        .FRAC_W (FRAC_W)
    ) fx_arith_inst (
        .i_op (i_op),
        .i_a  (opnd_a),
        .i_b  (opnd_b),
        .o_y  (arith_y)
    );

    scramble_regs scramble_regs_inst (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_load_rot  (i_load_rot),
        .i_step_rot  (i_step_rot),
        .i_load_lfsr (i_load_lfsr),
        .i_step_lfsr (i_step_lfsr),
        .i_value     (arith_y),
        .o_rot       (rot),
        .o_lfsr      (lfsr)
    );

    // result and saved operand, both fed by the arithmetic unit
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_data  <= '0;
            o_saved <= '0;
        end else begin
            if (i_save_result)  o_data  <= arith_y;
            if (i_save_operand) o_saved <= arith_y;
        end
    end

endmodule

/* source/alu_ctrl.sv */
`timescale 1ns/1ps

module alu_ctrl import alu_isa_pkg::*, alu_ctrl_pkg::*; (
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  inst_e i_inst,
    input  data_t i_saved,
    output logic  o_busy,
    output logic  o_valid,
    output src_e  o_src_a,
    output src_e  o_src_b,
    output op_e   o_op,
    output logic  o_save_result,
    output logic  o_save_operand,
    output logic  o_load_rot,
    output logic  o_step_rot,
    output logic  o_load_lfsr,
    output logic  o_step_lfsr,
    output data_t o_count
);

    localparam int IDX_W = $clog2(DATA_W);

    typedef enum logic [3:0] {
        START, READY, WAIT, CALCULATE, MAC_ADD, CLZ_SCAN,
        LRCW_LOAD, LRCW_POP, LRCW_ROTATE, LFSR_LOAD, LFSR_STEP, FINISH
    } state_e;

    state_e state, next_state;

    logic [DATA_W-1:0] cnt0, cnt1;  // cnt0 indexes and steps, cnt1 counts ones
    logic clr_cnt0, clr_cnt1, step_cnt0, step_cnt1;
    logic [IDX_W-1:0] scan_idx;

    assign scan_idx = IDX_W'(DATA_W - 1) - cnt0[IDX_W-1:0];  // MSB first for CLZ

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state <= START;
            cnt0  <= '0;
            cnt1  <= '0;
        end else begin
            state <= next_state;
            if (clr_cnt0)       cnt0 <= '0;
            else if (step_cnt0) cnt0 <= cnt0 + 1'b1;
            if (clr_cnt1)       cnt1 <= '0;
            else if (step_cnt1) cnt1 <= cnt1 + 1'b1;
        end
    end

    always_comb begin
        next_state     = state;
        o_src_a        = SRC_DATA_A;
        o_src_b        = SRC_DATA_B;
        o_op           = OP_PASS_A;
        o_save_result  = 1'b0;
        o_save_operand = 1'b0;
        o_load_rot     = 1'b0;
        o_step_rot     = 1'b0;
        o_load_lfsr    = 1'b0;
        o_step_lfsr    = 1'b0;
        clr_cnt0       = 1'b0;
        clr_cnt1       = 1'b0;
        step_cnt0      = 1'b0;
        step_cnt1      = 1'b0;

        case (state)
            START: next_state = READY;
            READY: next_state = WAIT;  // operands sampled from here on
            WAIT: begin
                clr_cnt0   = 1'b1;  // counter 0 doubles as the zero source
                clr_cnt1   = 1'b1;
                next_state = CALCULATE;
            end
            CALCULATE: begin
                case (i_inst)
                    INST_ADD, INST_SUB, INST_MUL: begin
                        o_op          = (i_inst == INST_ADD) ? OP_ADD :
                                        (i_inst == INST_SUB) ? OP_SUB : OP_MUL;
                        o_save_result = 1'b1;
                        next_state    = FINISH;
                    end
                    INST_MAC: begin
                        o_op           = OP_MUL;  // product parked in saved reg
                        o_save_operand = 1'b1;
                        next_state     = MAC_ADD;
                    end
                    INST_CLZ: begin
                        o_save_operand = 1'b1;  // a passes through
                        next_state     = CLZ_SCAN;
                    end
                    INST_LRCW: begin
                        o_save_operand = 1'b1;
                        next_state     = LRCW_LOAD;
                    end
                    INST_LFSR: begin
                        o_src_a        = SRC_DATA_B;  // step count
                        o_save_operand = 1'b1;
                        next_state     = LFSR_LOAD;
                    end
                    default: begin
                        o_src_a       = SRC_COUNT;  // still zero after WAIT
                        o_save_result = 1'b1;
                        next_state    = FINISH;
                    end
                endcase
            end
            MAC_ADD: begin
                o_op          = OP_ADD;
                o_src_a       = SRC_SAVED;
                o_src_b       = SRC_RESULT;
                o_save_result = 1'b1;
                next_state    = FINISH;
            end
            CLZ_SCAN: begin
                if (cnt0 < DATA_W && !i_saved[scan_idx]) begin
                    step_cnt0 = 1'b1;
                end else begin
                    o_src_a       = SRC_COUNT;
                    o_save_result = 1'b1;
                    next_state    = FINISH;
                end
            end
            LRCW_LOAD: begin
                o_src_a    = SRC_DATA_B;
                o_load_rot = 1'b1;
                next_state = LRCW_POP;
            end
            LRCW_POP: begin
                if (cnt0 < DATA_W) begin
                    step_cnt0 = 1'b1;
                    step_cnt1 = i_saved[cnt0[IDX_W-1:0]];
                end else begin
                    clr_cnt0   = 1'b1;  // reuse as rotate index
                    next_state = LRCW_ROTATE;
                end
            end
            LRCW_ROTATE: begin
                if (cnt0 < cnt1) begin
                    o_step_rot = 1'b1;
                    step_cnt0  = 1'b1;
                end else begin
                    o_src_a       = SRC_GPR_ROT;
                    o_save_result = 1'b1;
                    next_state    = FINISH;
                end
            end
            LFSR_LOAD: begin
                o_load_lfsr = 1'b1;  // seed from a
                next_state  = LFSR_STEP;
            end
            LFSR_STEP: begin
                if (cnt0 < $unsigned(i_saved)) begin
                    o_step_lfsr = 1'b1;
                    step_cnt0   = 1'b1;
                end else begin
                    o_src_a       = SRC_GPR_LFSR;
                    o_save_result = 1'b1;
                    next_state    = FINISH;
                end
            end
            FINISH:  next_state = READY;
            default: next_state = START;
        endcase
    end

    assign o_busy  = (state != READY);
    assign o_valid = (state == FINISH);
    assign o_count = cnt0;

endmodule

/* source/alu_top.sv */
`timescale 1ns/1ps

module alu_top import alu_isa_pkg::*, alu_ctrl_pkg::*; #(
    parameter int FRAC_W = 10
) (
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  inst_e i_inst,
    input  data_t i_data_a,
    input  data_t i_data_b,
    output logic  o_valid,
    output logic  o_busy,
    output data_t o_data
);

    // controller to datapath
    src_e  src_a;
    src_e  src_b;
    op_e   op;
    logic  save_result;
    logic  save_operand;
    logic  load_rot;
    logic  step_rot;
    logic  load_lfsr;
    logic  step_lfsr;
    data_t count;

    data_t saved;  // back to the controller for bit tests and bounds

    alu_ctrl alu_ctrl_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_inst         (i_inst),
        .i_saved        (saved),
        .o_busy         (o_busy),
        .o_valid        (o_valid),
        .o_src_a        (src_a),
        .o_src_b        (src_b),
        .o_op           (op),
        .o_save_result  (save_result),
        .o_save_operand (save_operand),
        .o_load_rot     (load_rot),
        .o_step_rot     (step_rot),
        .o_load_lfsr    (load_lfsr),
        .o_step_lfsr    (step_lfsr),
        .o_count        (count)
    );

    alu_datapath #(
        .FRAC_W (FRAC_W)
    ) alu_datapath_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_data_a       (i_data_a),
        .i_data_b       (i_data_b),
        .i_src_a        (src_a),
        .i_src_b        (src_b),
        .i_op           (op),
        .i_save_result  (save_result),
        .i_save_operand (save_operand),
        .i_load_rot     (load_rot),
        .i_step_rot     (step_rot),
        .i_load_lfsr    (load_lfsr),
        .i_step_lfsr    (step_lfsr),
        .i_count        (count),
        .o_saved        (saved),
        .o_data         (o_data)
    );

endmodule

/* sim/alu_sva.sv */
`timescale 1ns/1ps

module alu_sva (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_valid,
    input logic i_busy
);

    int n_errors = 0;  // read by the testbench at the end

    // result pulse lasts a single cycle
    property valid_single;
        @(posedge i_clk) disable iff (!i_reset_n)
        i_valid |=> !i_valid;
    endproperty

    // back to READY right after the pulse
    property ready_after_valid;
        @(posedge i_clk) disable iff (!i_reset_n)
        i_valid |=> !i_busy;
    endproperty

    // no new operands accepted while a result is out
    property valid_while_busy;
        @(posedge i_clk) disable iff (!i_reset_n)
        !(i_valid && !i_busy);
    endproperty

    assert property (valid_single)
    else begin
        $error("o_valid stayed high for more than one cycle");
        n_errors++;
    end

    assert property (ready_after_valid)
    else begin
        $error("o_busy not low in the cycle after o_valid");
        n_errors++;
    end

    assert property (valid_while_busy)
    else begin
        $error("o_valid high while o_busy is low");
        n_errors++;
    end

endmodule

/* sim/tb_alu.sv */
`timescale 1ns/1ps

module tb_alu import alu_isa_pkg::*; ();

    localparam int FRAC_W  = 10;
    localparam int N_FIXED = 25;
    localparam int N_RAND  = 12;
    localparam int N_ROWS  = N_FIXED + N_RAND;
    localparam int TIMEOUT = 80 * N_ROWS + 20;  // in clock cycles

    logic  i_clk = 1'b0;
    logic  i_reset_n;
    inst_e i_inst;
    data_t i_data_a;
    data_t i_data_b;
    logic  o_valid;
    logic  o_busy;
    data_t o_data;

    // stimulus table with expected values
    string row_name [N_ROWS];
    inst_e row_inst [N_ROWS];
    data_t row_a    [N_ROWS];
    data_t row_b    [N_ROWS];
    data_t row_exp  [N_ROWS];
    int    row_lat  [N_ROWS];  // 0 where latency depends on the data
    int    n_built    = 0;
    data_t model_prev = '0;    // o_data as the model sees it

    int cycles = 0;
    int n_fail = 0;

    always #2 i_clk = ~i_clk;

    alu_top #(
        .FRAC_W (FRAC_W)
    ) alu_top_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_inst    (i_inst),
        .i_data_a  (i_data_a),
        .i_data_b  (i_data_b),
        .o_valid   (o_valid),
        .o_busy    (o_busy),
        .o_data    (o_data)
    );

    bind alu_top alu_sva alu_sva_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (o_valid),
        .i_busy    (o_busy)
    );

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout: the DUT gave no result within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic data_t clamp16(input int v);
        if (v > 32767)
            return 16'sh7FFF;
        if (v < -32768)
            return 16'sh8000;
        return data_t'(v);
    endfunction

    // fixed-point product, saturated on the integer part, rounded half up
    function automatic data_t mul_round(input data_t a, input data_t b);
        longint p;
        longint ip;
        longint max_int;
        p       = longint'(a) * longint'(b);
        ip      = p >>> (2 * FRAC_W);
        max_int = (longint'(1) << (DATA_W - FRAC_W - 1)) - 1;
        if (ip > max_int)
            return 16'sh7FFF;
        if (ip <= -max_int - 1)
            return 16'sh8000;
        return data_t'((p >>> FRAC_W) + ((p >>> (FRAC_W - 1)) & 1));  // no resat
    endfunction

    function automatic data_t lead_zeros(input data_t a);
        int n;
        n = 0;
        while (n < DATA_W && !a[DATA_W-1-n])
            n++;
        return data_t'(n);
    endfunction

    function automatic data_t comp_rotate(input data_t a, input data_t b);
        data_t r;
        r = b;
        repeat ($countones(a))
            r = {r[DATA_W-2:0], ~r[DATA_W-1]};
        return r;
    endfunction

    function automatic data_t lfsr_steps(input data_t a, input data_t b);
        data_t r;
        r = a;
        repeat (int'(b))
            r = {r[DATA_W-2:0], ^(r & LFSR_TAPS)};
        return r;
    endfunction

    function automatic data_t expected_result(input inst_e op, input data_t a,
                                              input data_t b, input data_t prev);
        case (op)
            INST_ADD:  return clamp16(int'(a) + int'(b));
            INST_SUB:  return clamp16(int'(a) - int'(b));
            INST_MUL:  return mul_round(a, b);
            INST_MAC:  return clamp16(int'(mul_round(a, b)) + int'(prev));
            INST_CLZ:  return lead_zeros(a);
            INST_LRCW: return comp_rotate(a, b);
            INST_LFSR: return lfsr_steps(a, b);
            default:   return '0;
        endcase
    endfunction

    // cycles from the READY cycle to o_valid
    function automatic int expected_latency(input inst_e op);
        case (op)
            INST_MAC:                      return 4;
            INST_CLZ, INST_LRCW, INST_LFSR: return 0;
            default:                       return 3;
        endcase
    endfunction

    task automatic add_row(input string name, input inst_e op, input data_t a, input data_t b);
        row_name[n_built] = name;
        row_inst[n_built] = op;
        row_a[n_built]    = a;
        row_b[n_built]    = b;
        row_exp[n_built]  = expected_result(op, a, b, model_prev);
        row_lat[n_built]  = expected_latency(op);
        model_prev        = row_exp[n_built];
        n_built++;
    endtask

    task automatic build_table();
        inst_e op;
        add_row("add", INST_ADD, 16'h0400, 16'h0200);
        add_row("add_pos_sat", INST_ADD, 16'h7000, 16'h2000);
        add_row("add_neg_sat", INST_ADD, 16'h9000, 16'hA000);
        add_row("sub", INST_SUB, 16'h0800, 16'h0C00);
        add_row("sub_pos_sat", INST_SUB, 16'h7000, 16'h9000);
        add_row("sub_neg_sat", INST_SUB, 16'h8800, 16'h1000);
        add_row("mul", INST_MUL, 16'h0600, 16'h0A00);
        add_row("mul_round_up", INST_MUL, 16'h0003, 16'h0155);
        add_row("mul_neg_frac", INST_MUL, 16'hFFFD, 16'h0100);
        add_row("mul_pos_sat", INST_MUL, 16'h4000, 16'h4000);
        add_row("mul_neg_sat", INST_MUL, 16'h4000, 16'hC000);
        add_row("mac", INST_MAC, 16'h0400, 16'h0600);  // adds onto the saturated result
        add_row("mac_sat", INST_MAC, 16'h7C00, 16'hFC00);  // -31 onto -30.5 clips low
        add_row("clz_one", INST_CLZ, 16'h0001, 16'h0000);
        add_row("clz_zero", INST_CLZ, 16'h0000, 16'h1234);
        add_row("clz_msb", INST_CLZ, 16'h8000, 16'h0000);
        add_row("clz_mid", INST_CLZ, 16'h00F0, 16'h0000);
        add_row("lrcw_four", INST_LRCW, 16'h000F, 16'h1234);
        add_row("lrcw_full", INST_LRCW, 16'hFFFF, 16'hA5A5);
        add_row("lrcw_none", INST_LRCW, 16'h0000, 16'h5555);
        add_row("lfsr_none", INST_LFSR, 16'hACE1, 16'd0);
        add_row("lfsr_17", INST_LFSR, 16'hACE1, 16'd17);
        add_row("lfsr_40", INST_LFSR, 16'h0001, 16'd40);
        add_row("unsupported_4", inst_e'(4'd4), 16'h1234, 16'h5678);
        add_row("unsupported_9", inst_e'(4'd9), 16'h7FFF, 16'h7FFF);
        for (int k = 0; k < N_RAND; k++) begin
            op = inst_e'($urandom % 3);  // ADD, SUB or MUL
            add_row($sformatf("rand_%0d", k), op, data_t'($urandom), data_t'($urandom));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
            n_fail++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s latency: expected %0d cycles, got %0d", name, exp, act);
            n_fail++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, got %b", name, exp, act);
            n_fail++;
        end
    endtask

    initial begin
        int t_ready;
        int n_before;
        i_reset_n = 1'b0;
        i_inst    = INST_ADD;
        i_data_a  = '0;
        i_data_b  = '0;
        void'($urandom(32'h195b));
        build_table();

        @(posedge i_clk);
        @(negedge i_clk);
        check_flag("reset_busy", 1'b1, o_busy);
        check_flag("reset_valid", 1'b0, o_valid);
        @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);  // START cycle
        check_flag("start_busy", 1'b1, o_busy);
        check_flag("start_valid", 1'b0, o_valid);
        check_data("start_data", '0, o_data);
        if (n_fail == 0)
            $display("[PASS] reset");

        for (int k = 0; k < N_ROWS; k++) begin
            n_before = n_fail;
            @(posedge i_clk);  // held from READY until o_valid
            i_inst   <= row_inst[k];
            i_data_a <= row_a[k];
            i_data_b <= row_b[k];
            @(negedge i_clk);
            while (o_busy)
                @(negedge i_clk);
            t_ready = cycles;
            @(negedge i_clk);
            while (!o_valid)
                @(negedge i_clk);
            check_data(row_name[k], row_exp[k], o_data);
            if (row_lat[k] != 0)
                check_latency(row_name[k], row_lat[k], cycles - t_ready);
            if (n_fail == n_before)
                $display("[PASS] %s: a=%h b=%h y=%h", row_name[k], row_a[k], row_b[k], o_data);
        end

        $display("%0d rows run, %0d check failures, %0d assertion failures",
                 N_ROWS, n_fail, alu_top_inst.alu_sva_inst.n_errors);
        if (n_fail == 0 && alu_top_inst.alu_sva_inst.n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
source/alu_isa_pkg.sv
source/alu_ctrl_pkg.sv
source/fx_arith.sv
source/scramble_regs.sv
source/alu_datapath.sv
source/alu_ctrl.sv
source/alu_top.sv
sim/alu_sva.sv
sim/tb_alu.sv

/* Bender.yml */
package:
  name: fx_alu

sources:
  - source/alu_isa_pkg.sv
  - source/alu_ctrl_pkg.sv
  - source/fx_arith.sv
  - source/scramble_regs.sv
  - source/alu_datapath.sv
  - source/alu_ctrl.sv
  - source/alu_top.sv
  - target: test
    files:
      - sim/alu_sva.sv
      - sim/tb_alu.sv
